// ==== include/params.svh ====
`ifndef PARAMS_SVH
`define PARAMS_SVH

// Physical byte address width.
// The cache tag and index split depends on it.
`define ALEN 43

`endif

// ==== hdl/addr_pkg.sv ====
`include "params.svh"

package addr_pkg;

	// Loads are whole 64-bit words.
	localparam int align_bits = 3;
	localparam int index_width = 8;
	localparam int aligned_width = `ALEN - align_bits;
	localparam int tag_width = aligned_width - index_width;

	// Byte address as seen at the request port.
	typedef logic [`ALEN-1:0] byte_addr_t;

	// Word address with the byte offset stripped.
	typedef logic [aligned_width-1:0] aligned_addr_t;

	// Low part of the word address, selects the cache entry.
	typedef logic [index_width-1:0] index_t;

	// High part, stored beside the data.
	typedef logic [tag_width-1:0] tag_t;

endpackage

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

	// ------------------------------------------------------------------
	// Geometry
	// ------------------------------------------------------------------
	// One 4 kbit BRAM is 256 x 16, six of them side by side per entry.
	localparam int data_width = 64;
	localparam int bram_blocks = 6;
	localparam int bram_addr_width = 8;
	localparam int bram_block_data_width = 16;
	localparam int entry_size = bram_blocks * bram_block_data_width;
	localparam int tag_size = entry_size - data_width;

	// ------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------
	typedef logic [data_width-1:0] data_t;

	// Hit reports the first lookup of the load, not the replay.
	typedef struct packed {
		data_t data;
		logic hit;
	} load_resp_t;

endpackage

// ==== hdl/bram.sv ====
`timescale 1ns/1ns

module bram #(
	parameter bit read_after_write = 1'b0,
	parameter int blocks = 1,
	parameter int block_addr_width = 8,
	parameter int block_data_width = 16
) (
	input logic clk,
	input logic [blocks-1:0] write_mask,
	input logic [block_addr_width-1:0] waddr,
	input logic [block_addr_width-1:0] raddr,
	input logic [blocks*block_data_width-1:0] wdata,
	output logic [blocks*block_data_width-1:0] rdata
);

	localparam int depth = 1 << block_addr_width;

	// One independent block per slice of the data word.
	for (genvar b = 0; b < blocks; b++) begin : g_block
		logic [block_data_width-1:0] mem [depth];
		logic [block_data_width-1:0] wslice;
		logic [block_data_width-1:0] rslice;
		logic fwd;

		assign wslice = wdata[b*block_data_width +: block_data_width];

		// New data wins when reading the address being written.
		assign fwd = read_after_write && write_mask[b] && (waddr == raddr);

		always_ff @(posedge clk) begin
			if (write_mask[b]) begin
				mem[waddr] <= wslice;
			end
			if (fwd) begin
				rslice <= wslice;
			end else begin
				rslice <= mem[raddr];
			end
		end

		assign rdata[b*block_data_width +: block_data_width] = rslice;
	end

endmodule

// ==== hdl/basic_cache.sv ====
`timescale 1ns/1ns

// Entry layout is | tag | data |, one entry per index.
module basic_cache #(
	parameter int blocks = cache_pkg::bram_blocks,
	parameter int block_addr_width = cache_pkg::bram_addr_width,
	parameter int block_data_width = cache_pkg::bram_block_data_width
) (
	input logic clk,
	input logic rst,
	input logic write_enable,
	input addr_pkg::aligned_addr_t waddr,
	input cache_pkg::data_t wdata,
	input addr_pkg::aligned_addr_t raddr,
	output cache_pkg::data_t rdata,
	output logic lookup_valid
);

	localparam int line_width = blocks * block_data_width;
	localparam int tag_width = addr_pkg::tag_width;
	localparam int data_width = cache_pkg::data_width;

	// ------------------------------------------------------------------
	// Geometry consistency, checked at elaboration
	// ------------------------------------------------------------------
	if (line_width != cache_pkg::entry_size) begin : g_bad_entry
		$error("basic_cache: BRAM width does not match the entry size");
	end
	if ($bits(addr_pkg::index_t) != block_addr_width) begin : g_bad_index
		$error("basic_cache: index width does not match the BRAM depth");
	end
	if (cache_pkg::tag_size != tag_width) begin : g_bad_tag
		$error("basic_cache: tag width does not fill the entry");
	end

	addr_pkg::index_t w_index;
	addr_pkg::tag_t w_tag;
	addr_pkg::index_t rd_index;
	addr_pkg::tag_t rd_tag;
	logic [line_width-1:0] line_wdata;
	logic [line_width-1:0] line_rdata;
	logic [blocks-1:0] write_mask;

	// Registered with the read.
	addr_pkg::index_t last_index;
	addr_pkg::tag_t last_tag;

	logic [(1<<block_addr_width)-1:0] valid_bits;
	addr_pkg::tag_t entry_tag;

	assign w_index = waddr[addr_pkg::index_width-1:0];
	assign w_tag = waddr[addr_pkg::aligned_width-1 -: tag_width];
	assign rd_index = raddr[addr_pkg::index_width-1:0];
	assign rd_tag = raddr[addr_pkg::aligned_width-1 -: tag_width];

	assign line_wdata = {w_tag, wdata};
	assign write_mask = {blocks{write_enable}};

	bram #(
		.read_after_write(1'b1),
		.blocks(blocks),
		.block_addr_width(block_addr_width),
		.block_data_width(block_data_width)
	) entry_ram (
		.clk(clk),
		.write_mask(write_mask),
		.waddr(w_index),
		.raddr(rd_index),
		.wdata(line_wdata),
		.rdata(line_rdata)
	);

	assign entry_tag = line_rdata[line_width-1 -: tag_width];
	assign rdata = line_rdata[data_width-1:0];
	assign lookup_valid = valid_bits[last_index] && (entry_tag == last_tag);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			last_index <= '0;
		end else begin
			if (write_enable) begin
				valid_bits[w_index] <= 1'b1;
			end
			last_index <= rd_index;
		end
	end

	// Tag of every read, compared one cycle later.
	always_ff @(posedge clk) begin
		last_tag <= rd_tag;
	end

endmodule

// ==== hdl/load_issue.sv ====
`timescale 1ns/1ns

module load_issue (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input addr_pkg::byte_addr_t req_addr,
	output logic req_ready,
	output addr_pkg::aligned_addr_t raddr,
	output logic lookup_active,
	output addr_pkg::aligned_addr_t lookup_addr,
	input logic miss,
	input logic refill_done
);

	typedef enum logic [2:0] {
		st_init,
		st_run,
		st_wait_refill,
		st_replay_miss,
		st_replay_held
	} state_t;

	state_t state;
	logic accept;

	// Load whose BRAM read happens on the next edge.
	logic issue_valid;
	addr_pkg::aligned_addr_t issue_addr;

	// Load whose lookup result is at the cache output.
	addr_pkg::aligned_addr_t look_addr;

	// Load that was behind the miss.
	logic held_valid;
	addr_pkg::aligned_addr_t held_addr;

	// Intake stops in the same cycle a miss shows up.
	assign req_ready = (state == st_run) && !miss;
	assign accept = req_valid && req_ready;

	assign raddr = issue_addr;
	assign lookup_active = issue_valid && !miss;
	assign lookup_addr = look_addr;

	// ------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_init;
			issue_valid <= 1'b0;
			held_valid <= 1'b0;
		end else begin
			case (state)
				st_init: begin
					state <= st_run;
				end
				st_run: begin
					issue_valid <= accept;
					if (miss) begin
						held_valid <= issue_valid;
						state <= st_wait_refill;
					end
				end
				st_wait_refill: begin
					if (refill_done) begin
						state <= st_replay_miss;
					end
				end
				st_replay_miss: begin
					issue_valid <= 1'b1;
					state <= held_valid ? st_replay_held : st_run;
				end
				st_replay_held: begin
					issue_valid <= 1'b1;
					held_valid <= 1'b0;
					state <= st_run;
				end
				default: begin
					state <= st_init;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Addresses
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			issue_addr <= req_addr[$bits(addr_pkg::byte_addr_t)-1:addr_pkg::align_bits];
		end else if (state == st_replay_miss) begin
			issue_addr <= look_addr;
		end else if (state == st_replay_held) begin
			issue_addr <= held_addr;
		end
		// Kept through the refill, since no lookup runs then.
		if (lookup_active) begin
			look_addr <= issue_addr;
		end
		if (state == st_run && miss) begin
			held_addr <= issue_addr;
		end
	end

endmodule

// ==== hdl/refill_unit.sv ====
`timescale 1ns/1ns

module refill_unit (
	input logic clk,
	input logic rst,
	input logic miss_start,
	input addr_pkg::aligned_addr_t miss_addr,
	output logic mem_req,
	output addr_pkg::aligned_addr_t mem_addr,
	input logic mem_ack,
	input cache_pkg::data_t mem_rdata,
	output logic write_enable,
	output addr_pkg::aligned_addr_t waddr,
	output cache_pkg::data_t wdata,
	output logic refill_done
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait,
		st_write
	} state_t;

	state_t state;

	// Line being refilled.
	addr_pkg::aligned_addr_t line_addr;
	cache_pkg::data_t line_data;

	assign mem_req = (state == st_request);
	assign mem_addr = line_addr;

	assign write_enable = (state == st_write);
	assign waddr = line_addr;
	assign wdata = line_data;

	// ------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			refill_done <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			case (state)
				st_idle: begin
					if (miss_start) begin
						state <= st_request;
					end
				end
				st_request: begin
					state <= st_wait;
				end
				st_wait: begin
					if (mem_ack) begin
						state <= st_write;
					end
				end
				st_write: begin
					// Entry is in the cache from this edge on.
					refill_done <= 1'b1;
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Address and data capture
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == st_idle && miss_start) begin
			line_addr <= miss_addr;
		end
		if (state == st_wait && mem_ack) begin
			line_data <= mem_rdata;
		end
	end

endmodule

// ==== hdl/load_pipeline_top.sv ====
`timescale 1ns/1ns

module load_pipeline_top (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input addr_pkg::byte_addr_t req_addr,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::load_resp_t resp,
	output logic mem_req,
	output addr_pkg::aligned_addr_t mem_addr,
	input logic mem_ack,
	input cache_pkg::data_t mem_rdata
);

	addr_pkg::aligned_addr_t raddr;
	logic lookup_active;
	addr_pkg::aligned_addr_t lookup_addr;
	cache_pkg::data_t cache_rdata;
	logic lookup_valid;

	logic write_enable;
	addr_pkg::aligned_addr_t waddr;
	cache_pkg::data_t wdata;
	logic refill_done;

	// Lookup stage tracking.
	logic look_valid;
	logic look_replay;
	logic replay_pending;
	logic miss;

	assign miss = look_valid && !lookup_valid;

	load_issue issue0 (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.raddr(raddr),
		.lookup_active(lookup_active),
		.lookup_addr(lookup_addr),
		.miss(miss),
		.refill_done(refill_done)
	);

	basic_cache #(
		.blocks(cache_pkg::bram_blocks),
		.block_addr_width(cache_pkg::bram_addr_width),
		.block_data_width(cache_pkg::bram_block_data_width)
	) cache0 (
		.clk(clk),
		.rst(rst),
		.write_enable(write_enable),
		.waddr(waddr),
		.wdata(wdata),
		.raddr(raddr),
		.rdata(cache_rdata),
		.lookup_valid(lookup_valid)
	);

	refill_unit refill0 (
		.clk(clk),
		.rst(rst),
		.miss_start(miss),
		.miss_addr(lookup_addr),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.write_enable(write_enable),
		.waddr(waddr),
		.wdata(wdata),
		.refill_done(refill_done)
	);

	// ------------------------------------------------------------------
	// Lookup tracking and response register
	// ------------------------------------------------------------------
	// The first lookup after a miss is always the missed load itself.
	always_ff @(posedge clk) begin
		if (rst) begin
			look_valid <= 1'b0;
			look_replay <= 1'b0;
			replay_pending <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			look_valid <= lookup_active;
			look_replay <= replay_pending && lookup_active;
			if (miss) begin
				replay_pending <= 1'b1;
			end else if (lookup_active) begin
				replay_pending <= 1'b0;
			end
			resp_valid <= look_valid && lookup_valid;
		end
	end

	always_ff @(posedge clk) begin
		resp.data <= cache_rdata;
		resp.hit <= !look_replay;
	end

endmodule

// ==== testbench/tb_backing_mem.sv ====
`timescale 1ns/1ns

// External memory with a random reply latency of 1 to 20 cycles.
module tb_backing_mem (
	input logic clk,
	input logic rst,
	input logic mem_req,
	input addr_pkg::aligned_addr_t mem_addr,
	output logic mem_ack,
	output cache_pkg::data_t mem_rdata
);

	logic busy;
	int unsigned wait_count;
	addr_pkg::aligned_addr_t req_addr;

	// Upper half is the low address word, lower half its inverse.
	function automatic cache_pkg::data_t word_of(addr_pkg::aligned_addr_t a);
		return {a[31:0], ~a[31:0]};
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			mem_ack <= 1'b0;
			mem_rdata <= '0;
			wait_count <= 0;
		end else begin
			mem_ack <= 1'b0;
			if (!busy && mem_req) begin
				busy <= 1'b1;
				req_addr <= mem_addr;
				wait_count <= 1 + ($urandom % 20);
			end else if (busy) begin
				if (wait_count == 1) begin
					mem_ack <= 1'b1;
					mem_rdata <= word_of(req_addr);
					busy <= 1'b0;
				end else begin
					wait_count <= wait_count - 1;
				end
			end
		end
	end

endmodule

// ==== testbench/tb_load_pipeline.sv ====
`timescale 1ns/1ns

module tb_load_pipeline;

	typedef struct packed {
		addr_pkg::byte_addr_t addr;
		logic [7:0] gap;
	} row_t;

	localparam int num_rows = 26;
	localparam int ready_timeout = 200;
	localparam int drain_timeout = 2000;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic req_valid = 1'b0;
	addr_pkg::byte_addr_t req_addr = '0;
	logic req_ready;
	logic resp_valid;
	cache_pkg::load_resp_t resp;
	logic mem_req;
	addr_pkg::aligned_addr_t mem_addr;
	logic mem_ack;
	cache_pkg::data_t mem_rdata;

	row_t rows [num_rows];
	addr_pkg::tag_t model_tag [256];
	bit model_valid [256];

	addr_pkg::aligned_addr_t exp_addr_q [$];
	bit exp_hit_q [$];
	int exp_cycle_q [$];
	addr_pkg::aligned_addr_t exp_miss_q [$];

	int cycle = 0;
	int accepted = 0;
	int answered = 0;
	int misses_sent = 0;
	int misses_answered = 0;
	bit refill_busy = 1'b0;

	load_pipeline_top dut0 (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp(resp),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	tb_backing_mem mem0 (
		.clk(clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// ------------------------------------------------------------------
	// Reference model and checks
	// ------------------------------------------------------------------
	function automatic cache_pkg::data_t expected_word(addr_pkg::aligned_addr_t a);
		return {a[31:0], ~a[31:0]};
	endfunction

	// Predicts the lookup in order and fills the line on a miss.
	function automatic bit predict_and_fill(addr_pkg::aligned_addr_t a);
		addr_pkg::index_t idx;
		addr_pkg::tag_t tag;
		bit hit;
		idx = a[7:0];
		tag = a[39:8];
		hit = model_valid[idx] && (model_tag[idx] == tag);
		model_valid[idx] = 1'b1;
		model_tag[idx] = tag;
		return hit;
	endfunction

	task automatic stop_failed(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input cache_pkg::data_t got, input cache_pkg::data_t exp,
			input string what);
		if (got !== exp) begin
			stop_failed($sformatf("FAILED at %0t: %s data %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_hit(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			stop_failed($sformatf("FAILED at %0t: %s is %0b, expected %0b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_addr(input addr_pkg::aligned_addr_t got,
			input addr_pkg::aligned_addr_t exp, input string what);
		if (got !== exp) begin
			stop_failed($sformatf("FAILED at %0t: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_failed($sformatf("FAILED at %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	// Response monitor that also watches the memory port and intake.
	always @(posedge clk) begin
		addr_pkg::aligned_addr_t a;
		bit exp_hit;
		int acc_cycle;
		if (!rst) begin
			if (mem_req) begin
				if (exp_miss_q.size() == 0) begin
					stop_failed("A memory request came with no miss outstanding.");
				end
				a = exp_miss_q.pop_front();
				check_addr(mem_addr, a, "memory request address");
			end
			if (mem_req) begin
				refill_busy <= 1'b1;
			end else if (mem_ack) begin
				refill_busy <= 1'b0;
			end
			if (refill_busy) begin
				check_hit(req_ready, 1'b0, "req_ready during refill");
			end
			if (resp_valid) begin
				if (exp_addr_q.size() == 0) begin
					stop_failed("A response came with no load outstanding.");
				end
				a = exp_addr_q.pop_front();
				exp_hit = exp_hit_q.pop_front();
				acc_cycle = exp_cycle_q.pop_front();
				check_data(resp.data, expected_word(a), "response");
				check_hit(resp.hit, exp_hit, "response hit bit");
				// Valid from edge N+2 and sampled at edge N+3.
				if (acc_cycle >= 0) begin
					check_count(cycle - acc_cycle, 3, "hit latency in edges");
				end
				if (!exp_hit) begin
					misses_answered <= misses_answered + 1;
				end
				answered <= answered + 1;
			end
		end
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	initial begin
		int r;
		int waited;
		bit done;
		bit hit;
		bit timed;
		bit prev_timed;
		addr_pkg::aligned_addr_t a;

		void'($urandom(32'h31e1_7b0f));
		for (int i = 0; i < 256; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i] = '0;
		end

		// First touch, repeat, then three lines back to back.
		rows[0] = '{43'h000_0000_1008, 8'd0};
		rows[1] = '{43'h000_0000_1008, 8'd5};
		rows[2] = '{43'h000_0000_1010, 8'd5};
		rows[3] = '{43'h000_0000_1018, 8'd5};
		rows[4] = '{43'h000_0000_1008, 8'd40};
		rows[5] = '{43'h000_0000_1010, 8'd0};
		rows[6] = '{43'h000_0000_1018, 8'd0};
		// Same index, different tags.
		rows[7] = '{43'h000_0000_2020, 8'd5};
		rows[8] = '{43'h000_0001_2020, 8'd5};
		rows[9] = '{43'h000_0000_2020, 8'd5};
		rows[10] = '{43'h000_0001_2020, 8'd5};
		rows[11] = '{43'h000_0000_2020, 8'd5};
		rows[12] = '{43'h000_0001_2020, 8'd5};
		// Loads held behind a miss.
		rows[13] = '{43'h000_0000_3000, 8'd5};
		rows[14] = '{43'h000_0000_3100, 8'd0};
		rows[15] = '{43'h000_0000_4000, 8'd5};
		rows[16] = '{43'h000_0000_4000, 8'd0};
		rows[17] = '{43'h000_0000_5000, 8'd5};
		rows[18] = '{43'h000_0000_1008, 8'd0};
		rows[19] = '{43'h000_0000_1010, 8'd0};
		// Byte offsets within one word.
		rows[20] = '{43'h000_0000_1013, 8'd5};
		rows[21] = '{43'h000_0000_1017, 8'd0};
		rows[22] = '{43'h000_0000_1011, 8'd0};
		rows[23] = '{43'h7ff_ffff_f018, 8'd5};
		rows[24] = '{43'h7ff_ffff_f01f, 8'd0};
		rows[25] = '{43'h000_0000_3104, 8'd3};

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_hit(req_ready, 1'b0, "req_ready right after reset");
		check_hit(resp_valid, 1'b0, "resp_valid after reset");
		check_hit(mem_req, 1'b0, "mem_req after reset");

		prev_timed = 1'b0;
		for (r = 0; r < num_rows; r++) begin
			if (rows[r].gap != 0) begin
				req_valid <= 1'b0;
				repeat (rows[r].gap) @(posedge clk);
			end
			req_valid <= 1'b1;
			req_addr <= rows[r].addr;
			done = 1'b0;
			waited = 0;
			while (!done) begin
				@(posedge clk);
				if (req_ready) begin
					done = 1'b1;
				end else begin
					waited++;
					if (waited > ready_timeout) begin
						stop_failed("Timed out waiting for req_ready.");
					end
				end
			end
			// Behind a hit with no refill, intake takes a load every cycle.
			if (rows[r].gap == 0 && prev_timed) begin
				check_count(waited, 0, "cycles without req_ready behind a hit");
			end
			a = rows[r].addr[42:3];
			hit = predict_and_fill(a);
			exp_addr_q.push_back(a);
			exp_hit_q.push_back(hit);
			// Fixed latency only holds with no refill in progress.
			timed = hit && (misses_sent == misses_answered);
			if (timed) begin
				exp_cycle_q.push_back(cycle);
			end else begin
				exp_cycle_q.push_back(-1);
			end
			if (!hit) begin
				misses_sent++;
				exp_miss_q.push_back(a);
			end
			prev_timed = timed;
			accepted++;
		end
		req_valid <= 1'b0;

		waited = 0;
		while (answered != accepted) begin
			@(posedge clk);
			waited++;
			if (waited > drain_timeout) begin
				stop_failed("Timed out waiting for the remaining responses.");
			end
		end
		// A stray response in this window stops the run in the monitor.
		repeat (20) @(posedge clk);

		$display("Test OK");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
hdl/addr_pkg.sv
hdl/cache_pkg.sv
hdl/bram.sv
hdl/basic_cache.sv
hdl/load_issue.sv
hdl/refill_unit.sv
hdl/load_pipeline_top.sv
testbench/tb_backing_mem.sv
testbench/tb_load_pipeline.sv

// ==== Makefile ====
TOP = tb_load_pipeline
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module load_pipeline_top

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
